// ==== include/hps_cfg.svh ====
// host I/O bridge configuration: bus widths, command codes and string length
`ifndef HPS_CFG_SVH
`define HPS_CFG_SVH

////////////////////////////////////////////////////////////
// host word bus
////////////////////////////////////////////////////////////

// one word per strobe on the host bus
`define HPS_WORD_W 16

// payload word counter, saturates at all ones
`define HPS_CNT_W 10

// characters in the config string, first character in the top byte
`define HPS_CONF_STRLEN 12

// download byte address
`define HPS_ADDR_W 25

////////////////////////////////////////////////////////////
// command codes, compared against the full command word
////////////////////////////////////////////////////////////

`define HPS_CMD_CFG      16'h0001
`define HPS_CMD_JOY0     16'h0002
`define HPS_CMD_JOY1     16'h0003
`define HPS_CMD_CONF_STR 16'h0014
`define HPS_CMD_STATUS   16'h001E
`define HPS_CMD_FILE_TX  16'h0053
`define HPS_CMD_FILE_DAT 16'h0054
`define HPS_CMD_FILE_IDX 16'h0055

`endif

// ==== design/hps_bus_pkg.sv ====
// host bus types: bus words, payload word numbers and frame states
`include "hps_cfg.svh"

package hps_bus_pkg;

	////////////////////////////////////////////////////////////
	// words on the host bus
	////////////////////////////////////////////////////////////

	// one strobed word, command or payload
	typedef logic [`HPS_WORD_W-1:0] host_word_t;

	// payload word number, 1 is the first word after the command
	typedef logic [`HPS_CNT_W-1:0] word_cnt_t;

	////////////////////////////////////////////////////////////
	// frame tracking
	////////////////////////////////////////////////////////////

	// frame_idle    no frame open
	// frame_cmd     frame open, command word not yet strobed
	// frame_payload command captured, strobes carry payload
	typedef enum logic [1:0] {
		frame_idle    = 2'd0,
		frame_cmd     = 2'd1,
		frame_payload = 2'd2
	} frame_state_t;

endpackage

// ==== design/hps_ctrl_pkg.sv ====
// control side types: config, joystick and status registers, download sink
`include "hps_cfg.svh"

package hps_ctrl_pkg;

	////////////////////////////////////////////////////////////
	// control registers
	////////////////////////////////////////////////////////////

	// bits 1:0 buttons, bit 4 forced scandoubler
	typedef logic [7:0] cfg_byte_t;

	// one digital joystick, one bit per button or direction
	typedef logic [15:0] joystick_t;

	// status word, written as two 16-bit halves
	typedef logic [31:0] status_t;

	////////////////////////////////////////////////////////////
	// download sink
	////////////////////////////////////////////////////////////

	// menu index of the file being sent
	typedef logic [7:0] file_index_t;

	// byte address inside the file, also the byte count after stop
	typedef logic [`HPS_ADDR_W-1:0] file_addr_t;

	// one data byte toward the sink
	typedef logic [7:0] file_byte_t;

endpackage

// ==== design/host_word_if.sv ====
// decoded host payload words from the bus front end to the register file and loader
`timescale 1ns/1ps

interface host_word_if;

	// one-cycle pulse per payload word
	logic word_valid;

	// command word of the open frame
	hps_bus_pkg::host_word_t cmd;

	// payload word number, starting at 1
	hps_bus_pkg::word_cnt_t word_num;

	// payload word, meaningful only with word_valid
	hps_bus_pkg::host_word_t word;

	// one-cycle pulse after the frame closes
	logic frame_end;

	modport frontend (
		output word_valid,
		output cmd,
		output word_num,
		output word,
		output frame_end
	);

	modport regs (
		input word_valid,
		input cmd,
		input word_num,
		input word,
		input frame_end
	);

	modport loader (
		input word_valid,
		input cmd,
		input word_num,
		input word,
		input frame_end
	);

endinterface

// ==== design/host_bus_frontend.sv ====
// host bus front end: frame FSM, payload numbering, reply word and wait toward the host
`timescale 1ns/1ps

module host_bus_frontend (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    io_enable,
	input  logic                    io_strobe,
	input  hps_bus_pkg::host_word_t io_din,
	input  hps_bus_pkg::host_word_t reply,
	input  logic                    ioctl_wait,
	output hps_bus_pkg::host_word_t io_dout,
	output logic                    io_wait,
	host_word_if.frontend           words
);

	hps_bus_pkg::frame_state_t state;

	// number given to the next payload word
	hps_bus_pkg::word_cnt_t next_num;

	logic cmd_strobe;
	logic pay_strobe;

	// first strobe of a frame is the command, all later ones are payload
	assign cmd_strobe = io_enable && io_strobe && (state != hps_bus_pkg::frame_payload);
	assign pay_strobe = io_enable && io_strobe && (state == hps_bus_pkg::frame_payload);

	////////////////////////////////////////////////////////////
	// frame FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= hps_bus_pkg::frame_idle;
		end else if (!io_enable) begin
			state <= hps_bus_pkg::frame_idle;
		end else begin
			case (state)
				hps_bus_pkg::frame_idle:
					state <= io_strobe ? hps_bus_pkg::frame_payload : hps_bus_pkg::frame_cmd;
				hps_bus_pkg::frame_cmd:
					if (io_strobe) state <= hps_bus_pkg::frame_payload;
				default:
					state <= hps_bus_pkg::frame_payload;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// command capture and word numbering
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			words.cmd       <= '0;
			words.frame_end <= 1'b0;
			next_num        <= '0;
		end else begin
			words.frame_end <= !io_enable && (state != hps_bus_pkg::frame_idle);
			if (cmd_strobe) begin
				words.cmd <= io_din;
				next_num  <= hps_bus_pkg::word_cnt_t'(1);
			end else if (pay_strobe) begin
				// counter holds at its top value on very long frames
				if (next_num != '1) next_num <= next_num + 1'b1;
			end else if (words.frame_end) begin
				// no stale command once the frame is closed
				words.cmd <= '0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) words.word_valid <= 1'b0;
		else words.word_valid <= pay_strobe;
	end

	always_ff @(posedge clk_sys) begin
		if (pay_strobe) begin
			words.word     <= io_din;
			words.word_num <= next_num;
		end
	end

	////////////////////////////////////////////////////////////
	// reply word and wait toward the host
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) io_dout <= '0;
		else if (!io_enable) io_dout <= '0;
		else if (words.word_valid) io_dout <= reply;
	end

	// no buffering here, the sink's wait goes straight to the host
	assign io_wait = ioctl_wait;

endmodule

// ==== design/host_reg_file.sv ====
// control register file with config byte, joysticks, status word and config string readback
`timescale 1ns/1ps
`include "hps_cfg.svh"

module host_reg_file (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic [8*`HPS_CONF_STRLEN-1:0]  conf_str,
	output logic [1:0]                     buttons,
	output logic                           forced_scandoubler,
	output hps_ctrl_pkg::joystick_t        joystick_0,
	output hps_ctrl_pkg::joystick_t        joystick_1,
	output hps_ctrl_pkg::status_t          status,
	output hps_bus_pkg::host_word_t        reply,
	host_word_if.regs                      words
);

	hps_ctrl_pkg::cfg_byte_t cfg;

	logic first_word;
	logic second_word;
	logic str_hit;

	assign first_word  = words.word_valid && (words.word_num == hps_bus_pkg::word_cnt_t'(1));
	assign second_word = words.word_valid && (words.word_num == hps_bus_pkg::word_cnt_t'(2));

	////////////////////////////////////////////////////////////
	// register writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else begin
			case (words.cmd)
				`HPS_CMD_CFG: begin
					// only the low byte carries switches
					if (first_word) cfg <= words.word[7:0];
				end
				`HPS_CMD_JOY0: begin
					if (first_word) joystick_0 <= words.word;
				end
				`HPS_CMD_JOY1: begin
					if (first_word) joystick_1 <= words.word;
				end
				`HPS_CMD_STATUS: begin
					// low half first, then high half
					if (first_word) status[15:0] <= words.word;
					if (second_word) status[31:16] <= words.word;
				end
				default: begin
				end
			endcase
		end
	end

	// buttons in bits 1:0 and the scandoubler switch in bit 4
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	////////////////////////////////////////////////////////////
	// config string readback
	////////////////////////////////////////////////////////////

	// word n of the frame returns character n
	assign str_hit = (words.cmd == `HPS_CMD_CONF_STR)
		&& (words.word_num != '0)
		&& (words.word_num <= `HPS_CONF_STRLEN);

	// character 1 sits in the top byte of conf_str
	always_comb begin
		reply = '0;
		if (str_hit) begin
			reply[7:0] = conf_str[(`HPS_CONF_STRLEN - words.word_num) * 8 +: 8];
		end
	end

endmodule

// ==== design/file_loader.sv ====
// file download sink with file index, start/stop flag, byte address and write pulse
`timescale 1ns/1ps
`include "hps_cfg.svh"

module file_loader (
	input  logic                       clk_sys,
	input  logic                       reset,
	output logic                       ioctl_download,
	output hps_ctrl_pkg::file_index_t  ioctl_index,
	output logic                       ioctl_wr,
	output hps_ctrl_pkg::file_addr_t   ioctl_addr,
	output hps_ctrl_pkg::file_byte_t   ioctl_dout,
	host_word_if.loader                words
);

	// address of the next data byte and the byte count after stop
	hps_ctrl_pkg::file_addr_t addr;

	logic idx_word;
	logic tx_word;
	logic dat_word;

	assign idx_word = words.word_valid && (words.cmd == `HPS_CMD_FILE_IDX);
	assign tx_word  = words.word_valid && (words.cmd == `HPS_CMD_FILE_TX);
	assign dat_word = words.word_valid && (words.cmd == `HPS_CMD_FILE_DAT);

	////////////////////////////////////////////////////////////
	// index, start/stop and address
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			addr           <= '0;
		end else begin
			// one pulse per data word
			ioctl_wr <= dat_word;

			if (idx_word) ioctl_index <= words.word[7:0];

			if (tx_word) begin
				if (|words.word[7:0]) begin
					// start of transfer
					addr           <= '0;
					ioctl_download <= 1'b1;
				end else begin
					// end of transfer reports the byte count
					ioctl_addr     <= addr;
					ioctl_download <= 1'b0;
				end
			end

			if (dat_word) begin
				ioctl_addr <= addr;
				addr       <= addr + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// data byte
	////////////////////////////////////////////////////////////

	// 8-bit path drops the upper byte of the word
	always_ff @(posedge clk_sys) begin
		if (dat_word) ioctl_dout <= words.word[7:0];
	end

endmodule

// ==== design/hps_io_core.sv ====
// host I/O bridge top: front end, control registers and file loader on one word stream
`timescale 1ns/1ps
`include "hps_cfg.svh"

module hps_io_core (
	input  logic                           clk_sys,
	input  logic                           reset,

	// host word bus
	input  logic                           io_enable,
	input  logic                           io_strobe,
	input  logic [`HPS_WORD_W-1:0]         io_din,
	output logic [`HPS_WORD_W-1:0]         io_dout,
	output logic                           io_wait,

	// fixed config string
	input  logic [8*`HPS_CONF_STRLEN-1:0]  conf_str,

	// control registers
	output logic [1:0]                     buttons,
	output logic                           forced_scandoubler,
	output logic [15:0]                    joystick_0,
	output logic [15:0]                    joystick_1,
	output logic [31:0]                    status,

	// download sink
	output logic                           ioctl_download,
	output logic [7:0]                     ioctl_index,
	output logic                           ioctl_wr,
	output logic [`HPS_ADDR_W-1:0]         ioctl_addr,
	output logic [7:0]                     ioctl_dout,
	input  logic                           ioctl_wait
);

	host_word_if words ();

	// reply word from the register file
	hps_bus_pkg::host_word_t reply;

	host_bus_frontend i_frontend (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_enable  (io_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.reply      (reply),
		.ioctl_wait (ioctl_wait),
		.io_dout    (io_dout),
		.io_wait    (io_wait),
		.words      (words.frontend)
	);

	host_reg_file i_reg_file (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.conf_str           (conf_str),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.reply              (reply),
		.words              (words.regs)
	);

	file_loader i_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.words          (words.loader)
	);

endmodule

// ==== verification/hps_io_tb.sv ====
// testbench for the host I/O bridge with random host frames checked against a reference model
`timescale 1ns/1ps
`include "hps_cfg.svh"

module hps_io_tb;

	localparam int WAIT_LIMIT = 200;

	logic clk_sys;
	logic reset;
	logic io_enable;
	logic io_strobe;
	logic io_wait;
	logic ioctl_wait;
	hps_bus_pkg::host_word_t io_din;
	hps_bus_pkg::host_word_t io_dout;
	logic [8*`HPS_CONF_STRLEN-1:0] conf_str;
	logic [1:0] buttons;
	logic forced_scandoubler;
	hps_ctrl_pkg::joystick_t joystick_0;
	hps_ctrl_pkg::joystick_t joystick_1;
	hps_ctrl_pkg::status_t status;
	logic ioctl_download;
	logic ioctl_wr;
	hps_ctrl_pkg::file_index_t ioctl_index;
	hps_ctrl_pkg::file_addr_t ioctl_addr;
	hps_ctrl_pkg::file_byte_t ioctl_dout;

	integer seed;
	int errors;
	int checks;
	int wr_count;
	logic wait_mode;

	// reference model
	hps_ctrl_pkg::cfg_byte_t exp_cfg;
	hps_ctrl_pkg::joystick_t exp_joy0;
	hps_ctrl_pkg::joystick_t exp_joy1;
	hps_ctrl_pkg::status_t exp_status;
	hps_ctrl_pkg::file_index_t exp_index;
	logic [7:0] conf_chars [1:`HPS_CONF_STRLEN];
	hps_ctrl_pkg::file_addr_t exp_wr_addr [$];
	hps_ctrl_pkg::file_byte_t exp_wr_byte [$];
	hps_bus_pkg::host_word_t frame_words [$];

	hps_io_core i_dut (
		.clk_sys(clk_sys), .reset(reset), .io_enable(io_enable), .io_strobe(io_strobe),
		.io_din(io_din), .io_dout(io_dout), .io_wait(io_wait), .conf_str(conf_str),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler),
		.joystick_0(joystick_0), .joystick_1(joystick_1), .status(status),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wait(ioctl_wait)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h",
				$time, name, actual, expected);
		end
	endtask

	task finish_run;
		$display("%0d checks, %0d errors, %0d write pulses", checks, errors, wr_count);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	// sink back-pressure only while wait_mode is on
	task set_wait;
		if (wait_mode) ioctl_wait = (($random(seed) & 3) == 0);
		else ioctl_wait = 1'b0;
	endtask

	task idle_cycle;
		@(negedge clk_sys);
		check("io_wait", io_wait, ioctl_wait);
		set_wait();
	endtask

	// one strobed word held off while io_wait is high
	task strobe_word(input hps_bus_pkg::host_word_t w);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		check("io_wait", io_wait, ioctl_wait);
		while (io_wait && waited < WAIT_LIMIT) begin
			set_wait();
			@(negedge clk_sys);
			check("io_wait", io_wait, ioctl_wait);
			waited++;
		end
		if (io_wait) begin
			errors++;
			$display("timeout: io_wait stayed high for %0d cycles", WAIT_LIMIT);
			finish_run();
		end else begin
			io_strobe = 1'b1;
			io_din    = w;
			@(negedge clk_sys);
			io_strobe = 1'b0;
			io_din    = '0;
			set_wait();
		end
	endtask

	task close_frame;
		idle_cycle();
		io_enable = 1'b0;
		idle_cycle();
		idle_cycle();
		check("io_dout", io_dout, 32'd0);
	endtask

	task send_frame(input hps_bus_pkg::host_word_t cmd);
		idle_cycle();
		io_enable = 1'b1;
		strobe_word(cmd);
		foreach (frame_words[i]) begin
			repeat ($unsigned($random(seed)) % 3) idle_cycle();
			strobe_word(frame_words[i]);
		end
		close_frame();
	endtask

	task check_regs;
		check("joystick_0", joystick_0, exp_joy0);
		check("joystick_1", joystick_1, exp_joy1);
		check("buttons", buttons, exp_cfg[1:0]);
		check("forced_scandoubler", forced_scandoubler, exp_cfg[4]);
		check("status", status, exp_status);
	endtask

	// reply n of the frame sampled 2 cycles after its strobe
	task conf_frame;
		hps_bus_pkg::host_word_t expected;
		idle_cycle();
		io_enable = 1'b1;
		strobe_word(`HPS_CMD_CONF_STR);
		for (int n = 1; n <= `HPS_CONF_STRLEN + 2; n++) begin
			strobe_word($random(seed));
			idle_cycle();
			if (n <= `HPS_CONF_STRLEN) expected = {8'h00, conf_chars[n]};
			else expected = '0;
			check("io_dout", io_dout, expected);
		end
		close_frame();
	endtask

	task run_download;
		int len;
		int start_count;
		hps_bus_pkg::host_word_t w;
		len = 1 + $unsigned($random(seed)) % 40;
		exp_index = $random(seed);
		frame_words.delete();
		frame_words.push_back({8'ha5, exp_index});
		send_frame(`HPS_CMD_FILE_IDX);
		check("ioctl_index", ioctl_index, exp_index);
		w = $random(seed);
		w[0] = 1'b1;
		frame_words.delete();
		frame_words.push_back(w);
		send_frame(`HPS_CMD_FILE_TX);
		check("ioctl_download", ioctl_download, 1'b1);
		start_count = wr_count;
		frame_words.delete();
		for (int i = 0; i < len; i++) begin
			w = $random(seed);
			frame_words.push_back(w);
			exp_wr_addr.push_back(i);
			exp_wr_byte.push_back(w[7:0]);
		end
		send_frame(`HPS_CMD_FILE_DAT);
		// stop flag is a zero low byte
		w = $random(seed);
		w[7:0] = 8'h00;
		frame_words.delete();
		frame_words.push_back(w);
		send_frame(`HPS_CMD_FILE_TX);
		check("ioctl_index", ioctl_index, exp_index);
		check("ioctl_download", ioctl_download, 1'b0);
		check("ioctl_addr", ioctl_addr, len);
		check("write pulse count", wr_count - start_count, len);
		check("pending bytes", exp_wr_addr.size(), 0);
	endtask

	////////////////////////////////////////////////////////////
	// write pulse monitor
	////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		if (!reset && ioctl_wr) begin
			if (exp_wr_addr.size() == 0) begin
				errors++;
				$display("ioctl_wr pulsed at %0t ns with no data byte sent", $time);
			end else begin
				check("ioctl_addr", ioctl_addr, exp_wr_addr.pop_front());
				check("ioctl_dout", ioctl_dout, exp_wr_byte.pop_front());
				wr_count++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int kind;
		seed = 43;
		errors = 0;
		checks = 0;
		wr_count = 0;
		wait_mode = 1'b0;
		reset = 1'b1;
		io_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		ioctl_wait = 1'b0;
		exp_cfg = '0;
		exp_joy0 = '0;
		exp_joy1 = '0;
		exp_status = '0;
		// character 1 ends up in the top byte
		conf_str = '0;
		for (int n = 1; n <= `HPS_CONF_STRLEN; n++) begin
			conf_chars[n] = 8'h21 + ($unsigned($random(seed)) % 90);
			conf_str = (conf_str << 8) | conf_chars[n];
		end
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
		idle_cycle();
		check_regs();
		check("io_dout", io_dout, 32'd0);
		check("ioctl_wr", ioctl_wr, 1'b0);
		check("ioctl_download", ioctl_download, 1'b0);
		check("ioctl_index", ioctl_index, 32'd0);
		check("ioctl_addr", ioctl_addr, 32'd0);
		repeat (30) begin
			kind = $unsigned($random(seed)) % 3;
			frame_words.delete();
			repeat (1 + $unsigned($random(seed)) % 3) frame_words.push_back($random(seed));
			case (kind)
				0: exp_joy0 = frame_words[0];
				1: exp_joy1 = frame_words[0];
				default: exp_cfg = frame_words[0][7:0];
			endcase
			if (kind == 0) send_frame(`HPS_CMD_JOY0);
			else if (kind == 1) send_frame(`HPS_CMD_JOY1);
			else send_frame(`HPS_CMD_CFG);
			check_regs();
		end
		repeat (4) begin
			frame_words.delete();
			repeat (2 + $unsigned($random(seed)) % 2) frame_words.push_back($random(seed));
			exp_status = {frame_words[1], frame_words[0]};
			send_frame(`HPS_CMD_STATUS);
			check_regs();
		end
		conf_frame();
		run_download();
		wait_mode = 1'b1;
		run_download();
		run_download();
		wait_mode = 1'b0;
		idle_cycle();
		finish_run();
	end

endmodule

// ==== sources.f ====
+incdir+include
design/hps_bus_pkg.sv
design/hps_ctrl_pkg.sv
design/host_word_if.sv
design/host_bus_frontend.sv
design/host_reg_file.sv
design/file_loader.sv
design/hps_io_core.sv
verification/hps_io_tb.sv
